// ==== common/tinker_pkg.sv ====
// Tinker core definitions
package tinker_pkg;

    typedef logic [63:0] word_t;    // Register value
    typedef logic [31:0] addr_t;    // PC and fetch address
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  opcode_t;  // Bits 31 to 27
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] lit_t;     // Bits 11 to 0

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        WRITEBACK,
        HALT
    } state_t;

    // --------------------------------------------------
    // Opcodes
    // --------------------------------------------------
    localparam opcode_t op_and    = 5'h00;
    localparam opcode_t op_or     = 5'h01;
    localparam opcode_t op_xor    = 5'h02;
    localparam opcode_t op_not    = 5'h03;
    localparam opcode_t op_shftr  = 5'h04;
    localparam opcode_t op_shftri = 5'h05;
    localparam opcode_t op_shftl  = 5'h06;
    localparam opcode_t op_shftli = 5'h07;
    localparam opcode_t op_br     = 5'h08;
    localparam opcode_t op_brr    = 5'h09;
    localparam opcode_t op_brr_l  = 5'h0a;
    localparam opcode_t op_brnz   = 5'h0b;
    localparam opcode_t op_brgt   = 5'h0e;
    localparam opcode_t op_halt   = 5'h0f;  // Halts only with literal 0
    localparam opcode_t op_mov    = 5'h11;
    localparam opcode_t op_mov_l  = 5'h12;
    localparam opcode_t op_add    = 5'h18;
    localparam opcode_t op_addi   = 5'h19;
    localparam opcode_t op_sub    = 5'h1a;
    localparam opcode_t op_subi   = 5'h1b;
    localparam opcode_t op_mul    = 5'h1c;
    localparam opcode_t op_div    = 5'h1d;

    localparam addr_t reset_pc    = 32'h0000_2000;
    localparam addr_t instr_bytes = 32'd4;
    localparam int    num_regs    = 32;

endpackage

// ==== common/exec_if.sv ====
// Execution unit bundle
interface exec_if (
    input logic clk
);

    // Decoded instruction and operands
    tinker_pkg::opcode_t opcode;
    tinker_pkg::lit_t    lit;
    tinker_pkg::word_t   op_a;
    tinker_pkg::word_t   op_b;
    tinker_pkg::addr_t   pc;

    // Unit results
    tinker_pkg::word_t   result;
    tinker_pkg::addr_t   next_pc;

    modport ctrl (output opcode, lit, op_a, op_b, pc, input result, next_pc);

    modport alu_side (input opcode, lit, op_a, op_b, output result);

    modport branch_side (input clk, opcode, lit, op_a, op_b, pc, output next_pc);

endinterface

// ==== execute/alu.sv ====
// Integer ALU
module alu (
    exec_if.alu_side ex
);

    tinker_pkg::word_t lit_sext;
    tinker_pkg::word_t lit_zext;

    assign lit_sext = {{52{ex.lit[11]}}, ex.lit};
    assign lit_zext = {52'b0, ex.lit};

    always_comb begin
        case (ex.opcode)
            // --------------------------------------------------
            // Arithmetic
            // --------------------------------------------------
            tinker_pkg::op_add:  ex.result = ex.op_a + ex.op_b;
            tinker_pkg::op_addi: ex.result = ex.op_a + lit_sext;
            tinker_pkg::op_sub:  ex.result = ex.op_a - ex.op_b;
            tinker_pkg::op_subi: ex.result = ex.op_a - lit_zext;
            tinker_pkg::op_mul:  ex.result = ex.op_a * ex.op_b;  // Low 64 bits
            tinker_pkg::op_div: begin
                if (ex.op_b == '0)
                    ex.result = '0;  // Divide by zero gives zero
                else
                    ex.result = ex.op_a / ex.op_b;
            end

            // Logic
            tinker_pkg::op_and: ex.result = ex.op_a & ex.op_b;
            tinker_pkg::op_or:  ex.result = ex.op_a | ex.op_b;
            tinker_pkg::op_xor: ex.result = ex.op_a ^ ex.op_b;
            tinker_pkg::op_not: ex.result = ~ex.op_a;

            // --------------------------------------------------
            // Shifts, logical only
            // --------------------------------------------------
            tinker_pkg::op_shftr:  ex.result = ex.op_a >> ex.op_b;
            tinker_pkg::op_shftri: ex.result = ex.op_a >> ex.lit;
            tinker_pkg::op_shftl:  ex.result = ex.op_a << ex.op_b;
            tinker_pkg::op_shftli: ex.result = ex.op_a << ex.lit;

            // Moves
            tinker_pkg::op_mov:   ex.result = ex.op_a;
            tinker_pkg::op_mov_l: ex.result = {ex.op_a[63:12], ex.lit};  // Keep upper bits

            default: ex.result = '0;
        endcase
    end

endmodule

// ==== execute/branch_unit.sv ====
// Branch target logic
module branch_unit (
    exec_if.branch_side ex
);

    tinker_pkg::addr_t seq_pc;
    tinker_pkg::addr_t lit_off;

    assign seq_pc  = ex.pc + tinker_pkg::instr_bytes;
    assign lit_off = {{20{ex.lit[11]}}, ex.lit};

    always_comb begin
        case (ex.opcode)
            tinker_pkg::op_br:    ex.next_pc = ex.op_a[31:0];
            tinker_pkg::op_brr:   ex.next_pc = ex.pc + ex.op_a[31:0];
            tinker_pkg::op_brr_l: ex.next_pc = ex.pc + lit_off;
            tinker_pkg::op_brnz: begin
                if (ex.op_a != '0)
                    ex.next_pc = ex.op_b[31:0];
                else
                    ex.next_pc = seq_pc;
            end
            tinker_pkg::op_brgt: begin
                // Taken holds the PC, the sequencer then loads r[rt]
                if ($signed(ex.op_a) > $signed(ex.op_b))
                    ex.next_pc = ex.pc;
                else
                    ex.next_pc = seq_pc;
            end
            default: ex.next_pc = seq_pc;
        endcase
    end

    a_next_pc_aligned: assert property (@(posedge ex.clk)
        ex.next_pc[1:0] == 2'b00);

endmodule

// ==== src/reg_file.sv ====
// General purpose registers
module reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::reg_idx_t rd_idx_a,
    input  tinker_pkg::reg_idx_t rd_idx_b,
    output tinker_pkg::word_t    rd_data_a,
    output tinker_pkg::word_t    rd_data_b,
    input  logic                 wr_en,
    input  tinker_pkg::reg_idx_t wr_idx,
    input  tinker_pkg::word_t    wr_data
);

    tinker_pkg::word_t regs [tinker_pkg::num_regs];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < tinker_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Combinational reads
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

    // The sequencer filters rd 0 before the write port
    a_no_r0_write: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (wr_idx != '0));

endmodule

// ==== src/sequencer.sv ====
// Instruction sequencer
module sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::instr_t   instr,
    output tinker_pkg::addr_t    fetch_addr,
    output tinker_pkg::reg_idx_t rd_idx_a,
    output tinker_pkg::reg_idx_t rd_idx_b,
    input  tinker_pkg::word_t    rd_data_a,
    input  tinker_pkg::word_t    rd_data_b,
    output logic                 wr_en,
    output tinker_pkg::reg_idx_t wr_idx,
    output tinker_pkg::word_t    wr_data,
    output logic                 hlt,
    exec_if.ctrl                 ex
);

    tinker_pkg::state_t   state;
    tinker_pkg::state_t   state_nxt;
    tinker_pkg::addr_t    pc;
    tinker_pkg::instr_t   ir;
    tinker_pkg::word_t    result_q;
    tinker_pkg::addr_t    next_pc_q;
    tinker_pkg::reg_idx_t dest_q;
    logic                 write_q;

    tinker_pkg::opcode_t  opcode;
    tinker_pkg::reg_idx_t rd;
    tinker_pkg::reg_idx_t rs;
    tinker_pkg::reg_idx_t rt;
    tinker_pkg::lit_t     lit;
    logic                 writes;
    logic                 is_halt;
    logic                 brgt_redirect;

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------
    assign opcode = ir[31:27];
    assign rd     = ir[26:22];
    assign rs     = ir[21:17];
    assign rt     = ir[16:12];
    assign lit    = ir[11:0];

    assign is_halt = (opcode == tinker_pkg::op_halt) && (lit == '0);

    // A taken brgt parks next_pc_q at the PC; its target r[rt] is read in WRITEBACK
    assign brgt_redirect = (state == tinker_pkg::WRITEBACK)
                        && (opcode == tinker_pkg::op_brgt) && (next_pc_q == pc);

    always_comb begin
        rd_idx_a = rs;
        rd_idx_b = rt;
        case (opcode)
            tinker_pkg::op_addi, tinker_pkg::op_subi, tinker_pkg::op_shftri,
            tinker_pkg::op_shftli, tinker_pkg::op_mov_l,
            tinker_pkg::op_br, tinker_pkg::op_brr: rd_idx_a = rd;
            tinker_pkg::op_brnz: rd_idx_b = rd;  // Condition rs, target rd
            tinker_pkg::op_brgt: begin
                if (state == tinker_pkg::WRITEBACK)
                    rd_idx_a = rt;   // Second half, jump target
                else
                    rd_idx_b = rd;   // First half, compare rs with rd
            end
            default: ;
        endcase
    end

    always_comb begin
        case (opcode)
            tinker_pkg::op_add, tinker_pkg::op_addi, tinker_pkg::op_sub,
            tinker_pkg::op_subi, tinker_pkg::op_mul, tinker_pkg::op_div,
            tinker_pkg::op_and, tinker_pkg::op_or, tinker_pkg::op_xor,
            tinker_pkg::op_not, tinker_pkg::op_shftr, tinker_pkg::op_shftri,
            tinker_pkg::op_shftl, tinker_pkg::op_shftli,
            tinker_pkg::op_mov, tinker_pkg::op_mov_l: writes = 1'b1;
            default: writes = 1'b0;
        endcase
    end

    // Second brgt half reuses the plain register jump
    assign ex.opcode = brgt_redirect ? tinker_pkg::op_br : opcode;
    assign ex.lit    = lit;
    assign ex.op_a   = rd_data_a;
    assign ex.op_b   = rd_data_b;
    assign ex.pc     = pc;

    // --------------------------------------------------
    // State machine
    // --------------------------------------------------
    always_comb begin
        case (state)
            tinker_pkg::FETCH:     state_nxt = tinker_pkg::DECODE;
            tinker_pkg::DECODE:    state_nxt = tinker_pkg::EXECUTE;
            tinker_pkg::EXECUTE:   state_nxt = is_halt ? tinker_pkg::HALT
                                                       : tinker_pkg::WRITEBACK;
            tinker_pkg::WRITEBACK: state_nxt = tinker_pkg::FETCH;
            default:               state_nxt = tinker_pkg::HALT;  // Held until reset
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= tinker_pkg::FETCH;
            pc      <= tinker_pkg::reset_pc;
            ir      <= '0;
            write_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == tinker_pkg::DECODE)
                ir <= instr;
            if (state == tinker_pkg::EXECUTE)
                write_q <= writes && (rd != '0);  // r0 stays zero
            if (state == tinker_pkg::WRITEBACK)
                pc <= brgt_redirect ? ex.next_pc : next_pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (state == tinker_pkg::EXECUTE) begin
            result_q  <= ex.result;
            next_pc_q <= ex.next_pc;
            dest_q    <= rd;
        end
    end

    assign fetch_addr = pc;
    assign wr_en      = (state == tinker_pkg::WRITEBACK) && write_q;
    assign wr_idx     = dest_q;
    assign wr_data    = result_q;
    assign hlt        = (state == tinker_pkg::HALT);

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

// ==== src/tinker_core.sv ====
// Tinker multicycle core
module tinker_core (
    input  logic                 clk,
    input  logic                 reset,
    output tinker_pkg::addr_t    fetch_addr,
    input  tinker_pkg::instr_t   instr,
    output logic                 wb_valid,
    output tinker_pkg::reg_idx_t wb_reg,
    output tinker_pkg::word_t    wb_data,
    output logic                 hlt
);

    tinker_pkg::reg_idx_t rd_idx_a;
    tinker_pkg::reg_idx_t rd_idx_b;
    tinker_pkg::word_t    rd_data_a;
    tinker_pkg::word_t    rd_data_b;

    exec_if ex (.clk(clk));

    // --------------------------------------------------
    // Control and state
    // --------------------------------------------------
    sequencer sequencer_i (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .fetch_addr (fetch_addr),
        .rd_idx_a   (rd_idx_a),
        .rd_idx_b   (rd_idx_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .wr_en      (wb_valid),  // Write port doubles as write-back report
        .wr_idx     (wb_reg),
        .wr_data    (wb_data),
        .hlt        (hlt),
        .ex         (ex.ctrl)
    );

    reg_file reg_file_i (
        .clk       (clk),
        .reset     (reset),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wb_valid),
        .wr_idx    (wb_reg),
        .wr_data   (wb_data)
    );

    // --------------------------------------------------
    // Execution units, side by side
    // --------------------------------------------------
    alu alu_i (
        .ex (ex.alu_side)
    );

    branch_unit branch_unit_i (
        .ex (ex.branch_side)
    );

endmodule

// ==== tests/tb_checks.svh ====
// Testbench compare tasks
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------------------------------------
// Fail path
// --------------------------------------------------
task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "first error ends the run");
endtask

// --------------------------------------------------
// Typed compares
// --------------------------------------------------
task automatic check_word(input string name, input tinker_pkg::word_t expected,
                          input tinker_pkg::word_t actual);
    if (actual !== expected)
        stop_with_failure($sformatf("CHECK FAILED at %0d ns: %s expected %h, got %h",
                                    $time, name, expected, actual));
endtask

task automatic check_reg_idx(input string name, input tinker_pkg::reg_idx_t expected,
                             input tinker_pkg::reg_idx_t actual);
    if (actual !== expected)
        stop_with_failure($sformatf("CHECK FAILED at %0d ns: %s expected r%0d, got r%0d",
                                    $time, name, expected, actual));
endtask

task automatic check_addr(input string name, input tinker_pkg::addr_t expected,
                          input tinker_pkg::addr_t actual);
    if (actual !== expected)
        stop_with_failure($sformatf("CHECK FAILED at %0d ns: %s expected %h, got %h",
                                    $time, name, expected, actual));
endtask

`endif

// ==== tests/tinker_core_tb.sv ====
// Tinker core testbench
module tinker_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int pat_words    = 384;  // Room for 128 records
    localparam int reset_cycles = 16;
    localparam int instr_len    = 4;    // Cycles per instruction
    localparam tinker_pkg::addr_t start_pc = 32'h0000_2000;  // First fetch after reset

    logic                 clk;
    logic                 reset;
    tinker_pkg::addr_t    fetch_addr;
    tinker_pkg::instr_t   instr;
    logic                 wb_valid;
    tinker_pkg::reg_idx_t wb_reg;
    tinker_pkg::word_t    wb_data;
    logic                 hlt;

    logic [63:0]          pat [pat_words];
    tinker_pkg::instr_t   imem [tinker_pkg::addr_t];  // Program words by address
    tinker_pkg::reg_idx_t exp_reg [$];
    tinker_pkg::word_t    exp_data [$];
    tinker_pkg::addr_t    final_pc;
    tinker_pkg::addr_t    last_fetch;
    int                   max_instrs;
    int                   max_cycles;
    int                   cycle_count;
    int                   wb_seen;
    int                   instr_cycles;

    `include "tb_checks.svh"

    tinker_core tinker_core_i (
        .clk        (clk),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .instr      (instr),
        .wb_valid   (wb_valid),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data),
        .hlt        (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------------------------------------
    // Pattern file
    // --------------------------------------------------
    task automatic load_patterns();
        int i;
        int k;
        for (i = 0; i < pat_words; i++) begin
            pat[i] = '0;
        end
        $readmemh("tests/tinker_core_patterns.txt", pat);
        k = 0;
        while (k + 2 < pat_words && pat[k] != 64'd0) begin
            case (pat[k])
                64'd1: imem[pat[k + 1][31:0]] = pat[k + 2][31:0];
                64'd2: begin
                    exp_reg.push_back(pat[k + 1][4:0]);
                    exp_data.push_back(pat[k + 2]);
                end
                64'd3: final_pc = pat[k + 1][31:0];
                64'd4: max_instrs = int'(pat[k + 1][31:0]);
                default: stop_with_failure($sformatf(
                    "pattern file has an unknown record kind %0d", pat[k]));
            endcase
            k += 3;
        end
        if (imem.size() == 0 || max_instrs == 0)
            stop_with_failure("pattern file holds no program or no instruction bound");
        max_cycles = reset_cycles + instr_len * max_instrs + 8;
    endtask

    // Next expected write-back, in program order
    task automatic match_writeback();
        if (wb_seen >= exp_reg.size())
            stop_with_failure($sformatf("unexpected write-back to r%0d at %0d ns",
                                        wb_reg, $time));
        check_reg_idx("wb_reg", exp_reg[wb_seen], wb_reg);
        check_word("wb_data", exp_data[wb_seen], wb_data);
        wb_seen++;
    endtask

    // --------------------------------------------------
    // Instruction memory and watchdog
    // --------------------------------------------------
    always @(negedge clk) begin
        if (imem.exists(fetch_addr))
            instr <= imem[fetch_addr];
        else if (reset === 1'b0)
            stop_with_failure($sformatf("core fetched from %h, outside the program",
                                        fetch_addr));
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles)
            stop_with_failure($sformatf("timeout after %0d cycles without a halt",
                                        cycle_count));
    end

    // --------------------------------------------------
    // Run
    // --------------------------------------------------
    initial begin
        reset       = 1'b1;
        instr       = '0;
        cycle_count = 0;
        wb_seen     = 0;
        max_instrs  = 0;
        final_pc    = '0;
        load_patterns();

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_addr("fetch_addr", start_pc, fetch_addr);
        if (wb_valid || hlt)
            stop_with_failure("wb_valid or hlt is high right after reset");

        last_fetch   = fetch_addr;
        instr_cycles = 0;
        while (!hlt) begin
            @(negedge clk);
            instr_cycles++;
            if (wb_valid)
                match_writeback();
            if (fetch_addr != last_fetch) begin  // Next instruction started
                if (instr_cycles != instr_len)
                    stop_with_failure($sformatf(
                        "CHECK FAILED at %0d ns: cycles at %h expected %0d, got %0d",
                        $time, last_fetch, instr_len, instr_cycles));
                last_fetch   = fetch_addr;
                instr_cycles = 0;
            end
        end

        if (wb_seen != exp_reg.size())
            stop_with_failure($sformatf("hlt rose after %0d of %0d expected write-backs",
                                        wb_seen, exp_reg.size()));
        check_addr("fetch_addr", final_pc, fetch_addr);

        // Halted core stays put
        repeat (instr_len) begin
            @(negedge clk);
            if (wb_valid)
                stop_with_failure("write-back seen after the core halted");
            if (!hlt)
                stop_with_failure("hlt dropped while reset was low");
            check_addr("fetch_addr", final_pc, fetch_addr);
        end

        $display("sim passed");
        $finish;
    end

endmodule

// ==== tinker_core.f ====
+incdir+tests
common/tinker_pkg.sv
common/exec_if.sv
execute/alu.sv
execute/branch_unit.sv
src/reg_file.sv
src/sequencer.sv
src/tinker_core.sv
tests/tinker_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = tinker_core_tb
FILELIST  = tinker_core.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tinker_core_patterns.txt ====
// Records of three hex words: kind, then two fields
// 1 addr word = program, 2 reg value = write-back in order, 3 pc 0 = final PC,
// 4 n 0 = bound on executed instructions
1 00002000 c8400005  2 01 0000000000000005  // addi r1, 5
1 00002004 c8800ffd  2 02 fffffffffffffffd  // addi r2, -3
1 00002008 c0c22000  2 03 0000000000000002  // add r3, r1, r2
1 0000200c e1021000  2 04 0000000000000019  // mul r4, r1, r1
1 00002010 e9480000  2 05 0000000000000000  // div r5, r4, r0 by zero
1 00002014 e9881000  2 06 0000000000000005  // div r6, r4, r1
1 00002018 d1c24000  2 07 ffffffffffffffec  // sub r7, r1, r4
1 0000201c d8400fff  2 01 fffffffffffff006  // subi r1, 0xfff zero-extended
1 00002020 1a060000  2 08 fffffffffffffffd  // not r8, r3
1 00002024 02501000  2 09 fffffffffffff004  // and r9, r8, r1
1 00002028 0a864000  2 0a 000000000000001b  // or r10, r3, r4
1 0000202c 12d46000  2 0b 000000000000001e  // xor r11, r10, r6
1 00002030 33083000  2 0c 0000000000000064  // shftl r12, r4, r3
1 00002034 23444000  2 0d 0000007fffffffff  // shftr r13, r2, r4
1 00002038 2a800004  2 0a 0000000000000001  // shftri r10, 4
1 0000203c 3ac00008  2 0b 0000000000001e00  // shftli r11, 8
1 00002040 8b920000  2 0e fffffffffffff004  // mov r14, r9
1 00002044 93800123  2 0e fffffffffffff123  // mov r14, 0x123
1 00002048 c8000007                         // addi r0, 7 with no write-back
1 0000204c c3c06000  2 0f 0000000000000005  // add r15, r0, r6 reads r0 as 0
1 00002050 cc000200  2 10 0000000000000200  // addi r16, 0x200
1 00002054 3c000004  2 10 0000000000002000  // shftli r16, 4
1 00002058 94000068  2 10 0000000000002068  // mov r16, 0x068
1 0000205c 44000000                         // br r16
1 00002060 cd000001                         // skipped
1 00002064 cd000002                         // skipped
1 00002068 cc40000c  2 11 000000000000000c  // addi r17, 12
1 0000206c 4c400000                         // brr r17
1 00002070 cd000003                         // skipped
1 00002074 cd000004                         // skipped
1 00002078 50000008                         // brr 8
1 0000207c cd000005                         // skipped
1 00002080 5c000000                         // brnz r16, r0 not taken
1 00002084 94000090  2 10 0000000000002090  // mov r16, 0x090
1 00002088 5c020000                         // brnz r16, r1 taken
1 0000208c cd000006                         // skipped
1 00002090 940000a0  2 10 00000000000020a0  // mov r16, 0x0a0
1 00002094 70c50000                         // brgt r3, r2, r16 not taken
1 00002098 70870000                         // brgt r2, r3, r16 taken
1 0000209c cd000007                         // skipped
1 000020a0 cc800001  2 12 0000000000000001  // addi r18, 1
1 000020a4 78000000                         // halt
3 000020a4 0                                // final PC
4 00000028 0                                // at most 40 instructions
